/* run_sim.sh */
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

verilator --binary --timing -f src.f --top-module tb_mem_subsys -Mdir obj_dir -o tb_mem_subsys
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_mem_subsys > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "No result line found in sim.log"
    exit 1
fi
exit 0

/* src.f */
+incdir+test
src/bus_pkg.sv
src/mem_pkg.sv
src/bus_arbiter.sv
src/req_latch.sv
src/access_timer.sv
src/sram_slave.sv
src/mem_subsys_top.sv
test/tb_mem_subsys.sv

/* src/access_timer.sv */
`timescale 1ns/100ps

module access_timer
    import mem_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic busy,
    output logic done
);

    lat_cnt_t cnt;

    // The start cycle is the first of the MEM_LATENCY cycles, so the
    // response flag set on done lands MEM_LATENCY edges after capture
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (start && !busy) begin
            cnt <= lat_cnt_t'(MEM_LATENCY - 1);
        end else if (busy) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign busy = (cnt != '0);
    assign done = (cnt == lat_cnt_t'(1));  // Last busy cycle

endmodule

/* src/bus_arbiter.sv */
`timescale 1ns/100ps

module bus_arbiter
    import bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    ifu_arvalid,
    output logic    ifu_arready,
    input  ar_req_t ifu_ar,
    output logic    ifu_rvalid,
    input  logic    ifu_rready,
    output r_resp_t ifu_r,

    input  logic    lsu_arvalid,
    output logic    lsu_arready,
    input  ar_req_t lsu_ar,
    output logic    lsu_rvalid,
    input  logic    lsu_rready,
    output r_resp_t lsu_r,
    input  logic    lsu_awvalid,
    output logic    lsu_awready,
    input  aw_req_t lsu_aw,
    input  logic    lsu_wvalid,
    output logic    lsu_wready,
    input  w_req_t  lsu_w,
    output logic    lsu_bvalid,
    input  logic    lsu_bready,
    output b_resp_t lsu_b,

    output logic    mem_arvalid,
    input  logic    mem_arready,
    output ar_req_t mem_ar,
    input  logic    mem_rvalid,
    output logic    mem_rready,
    input  r_resp_t mem_r,
    output logic    mem_awvalid,
    input  logic    mem_awready,
    output aw_req_t mem_aw,
    output logic    mem_wvalid,
    input  logic    mem_wready,
    output w_req_t  mem_w,
    input  logic    mem_bvalid,
    output logic    mem_bready,
    input  b_resp_t mem_b
);

    typedef enum logic [1:0] {
        IDLE,
        IFU_READ,
        LSU_WRITE,
        LSU_READ
    } arb_state_t;

    arb_state_t state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (ifu_arvalid) begin  // Fetch always wins
                        state <= IFU_READ;
                    end else if (lsu_awvalid) begin
                        state <= LSU_WRITE;
                    end else if (lsu_arvalid) begin
                        state <= LSU_READ;
                    end
                end
                IFU_READ: if (mem_rvalid && ifu_rready) state <= IDLE;
                LSU_WRITE: if (mem_bvalid && lsu_bready) state <= IDLE;
                LSU_READ: if (mem_rvalid && lsu_rready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Payloads follow the grant, handshakes are gated below
    assign mem_ar = (state == LSU_READ) ? lsu_ar : ifu_ar;
    assign mem_aw = lsu_aw;
    assign mem_w  = lsu_w;
    assign ifu_r  = mem_r;
    assign lsu_r  = mem_r;
    assign lsu_b  = mem_b;

    always_comb begin
        mem_arvalid = 1'b0;
        mem_rready  = 1'b0;
        mem_awvalid = 1'b0;
        mem_wvalid  = 1'b0;
        mem_bready  = 1'b0;
        ifu_arready = 1'b0;
        ifu_rvalid  = 1'b0;
        lsu_arready = 1'b0;
        lsu_rvalid  = 1'b0;
        lsu_awready = 1'b0;
        lsu_wready  = 1'b0;
        lsu_bvalid  = 1'b0;
        case (state)
            IFU_READ: begin
                mem_arvalid = ifu_arvalid;
                ifu_arready = mem_arready;
                ifu_rvalid  = mem_rvalid;
                mem_rready  = ifu_rready;
            end
            LSU_WRITE: begin
                mem_awvalid = lsu_awvalid;
                lsu_awready = mem_awready;
                mem_wvalid  = lsu_wvalid;
                lsu_wready  = mem_wready;
                lsu_bvalid  = mem_bvalid;
                mem_bready  = lsu_bready;
            end
            LSU_READ: begin
                mem_arvalid = lsu_arvalid;
                lsu_arready = mem_arready;
                lsu_rvalid  = mem_rvalid;
                mem_rready  = lsu_rready;
            end
            default: ;  // IDLE keeps every port quiet
        endcase
    end

endmodule

/* src/bus_pkg.sv */
package bus_pkg;

    typedef logic [31:0] addr_t;  // Byte address
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;  // One enable per byte lane
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    typedef struct packed {
        addr_t addr;
    } ar_req_t;

    typedef struct packed {
        addr_t addr;
    } aw_req_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_req_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } r_resp_t;

    typedef struct packed {
        resp_t resp;
    } b_resp_t;

endpackage

/* src/mem_pkg.sv */
package mem_pkg;

    // SRAM geometry, one 32-bit word per entry
    localparam int MEM_WORDS     = 256;
    localparam int WORD_IDX_BITS = $clog2(MEM_WORDS);  // Address bits 9..2

    // Decoded window is 1 KiB, anything at bit 10 or above is out of range
    localparam int WINDOW_BITS = WORD_IDX_BITS + 2;

    // Cycles from request capture to response valid
    localparam int MEM_LATENCY = 3;

    typedef logic [$clog2(MEM_LATENCY + 1)-1:0] lat_cnt_t;

endpackage

/* src/mem_subsys_top.sv */
`timescale 1ns/100ps

module mem_subsys_top
    import bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    ifu_arvalid,
    output logic    ifu_arready,
    input  ar_req_t ifu_ar,
    output logic    ifu_rvalid,
    input  logic    ifu_rready,
    output r_resp_t ifu_r,

    input  logic    lsu_arvalid,
    output logic    lsu_arready,
    input  ar_req_t lsu_ar,
    output logic    lsu_rvalid,
    input  logic    lsu_rready,
    output r_resp_t lsu_r,
    input  logic    lsu_awvalid,
    output logic    lsu_awready,
    input  aw_req_t lsu_aw,
    input  logic    lsu_wvalid,
    output logic    lsu_wready,
    input  w_req_t  lsu_w,
    output logic    lsu_bvalid,
    input  logic    lsu_bready,
    output b_resp_t lsu_b
);

    // Shared memory port between arbiter and SRAM
    logic    mem_arvalid;
    logic    mem_arready;
    ar_req_t mem_ar;
    logic    mem_rvalid;
    logic    mem_rready;
    r_resp_t mem_r;
    logic    mem_awvalid;
    logic    mem_awready;
    aw_req_t mem_aw;
    logic    mem_wvalid;
    logic    mem_wready;
    w_req_t  mem_w;
    logic    mem_bvalid;
    logic    mem_bready;
    b_resp_t mem_b;

    bus_arbiter u_arbiter (.*);

    sram_slave u_sram (
        .clk(clk), .rst(rst),
        .s_arvalid(mem_arvalid), .s_arready(mem_arready), .s_ar(mem_ar),
        .s_rvalid(mem_rvalid), .s_rready(mem_rready), .s_r(mem_r),
        .s_awvalid(mem_awvalid), .s_awready(mem_awready), .s_aw(mem_aw),
        .s_wvalid(mem_wvalid), .s_wready(mem_wready), .s_w(mem_w),
        .s_bvalid(mem_bvalid), .s_bready(mem_bready), .s_b(mem_b)
    );

endmodule

/* src/req_latch.sv */
`timescale 1ns/100ps

module req_latch
    import bus_pkg::*;
#(
    parameter type payload_t = ar_req_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     full,
    output payload_t data,
    input  logic     release_req
);

    assign in_ready = !full;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            full <= 1'b0;
        end else if (release_req) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end
    end

    // Payload only moves on an accepted transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data <= in_data;
        end
    end

endmodule

/* src/sram_slave.sv */
`timescale 1ns/100ps

module sram_slave
    import bus_pkg::*;
    import mem_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    s_arvalid,
    output logic    s_arready,
    input  ar_req_t s_ar,
    output logic    s_rvalid,
    input  logic    s_rready,
    output r_resp_t s_r,
    input  logic    s_awvalid,
    output logic    s_awready,
    input  aw_req_t s_aw,
    input  logic    s_wvalid,
    output logic    s_wready,
    input  w_req_t  s_w,
    output logic    s_bvalid,
    input  logic    s_bready,
    output b_resp_t s_b
);

    data_t   mem [MEM_WORDS];
    ar_req_t ar_q;
    aw_req_t aw_q;
    w_req_t  w_q;
    logic    ar_full;
    logic    aw_full;
    logic    w_full;
    logic    idle;
    logic    rd_start;
    logic    wr_start;
    logic    tmr_busy;
    logic    tmr_done;
    logic    op_read;  // Kind of access in flight
    logic    rd_in_range;
    logic    wr_in_range;
    logic [WORD_IDX_BITS-1:0] rd_idx;
    logic [WORD_IDX_BITS-1:0] wr_idx;

    req_latch #(.payload_t(ar_req_t)) u_ar_latch (
        .clk(clk), .rst(rst), .in_valid(s_arvalid), .in_ready(s_arready),
        .in_data(s_ar), .full(ar_full), .data(ar_q), .release_req(s_rvalid && s_rready)
    );
    req_latch #(.payload_t(aw_req_t)) u_aw_latch (
        .clk(clk), .rst(rst), .in_valid(s_awvalid), .in_ready(s_awready),
        .in_data(s_aw), .full(aw_full), .data(aw_q), .release_req(s_bvalid && s_bready)
    );
    req_latch #(.payload_t(w_req_t)) u_w_latch (
        .clk(clk), .rst(rst), .in_valid(s_wvalid), .in_ready(s_wready),
        .in_data(s_w), .full(w_full), .data(w_q), .release_req(s_bvalid && s_bready)
    );

    access_timer u_timer (
        .clk(clk), .rst(rst), .start(rd_start || wr_start), .busy(tmr_busy), .done(tmr_done)
    );

    assign idle     = !tmr_busy && !s_rvalid && !s_bvalid;
    assign rd_start = idle && ar_full;
    assign wr_start = idle && aw_full && w_full && !ar_full;  // Reads first

    assign rd_in_range = (ar_q.addr[31:WINDOW_BITS] == '0);
    assign wr_in_range = (aw_q.addr[31:WINDOW_BITS] == '0);
    assign rd_idx      = ar_q.addr[WORD_IDX_BITS+1:2];
    assign wr_idx      = aw_q.addr[WORD_IDX_BITS+1:2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_rvalid <= 1'b0;
            s_bvalid <= 1'b0;
            op_read  <= 1'b0;
        end else begin
            if (rd_start || wr_start) op_read <= rd_start;
            if (tmr_done) begin
                if (op_read) s_rvalid <= 1'b1;
                else s_bvalid <= 1'b1;
            end
            if (s_rvalid && s_rready) s_rvalid <= 1'b0;
            if (s_bvalid && s_bready) s_bvalid <= 1'b0;
        end
    end

    // Array and response payloads, sampled when the access starts
    always_ff @(posedge clk) begin
        if (rd_start) begin
            s_r.data <= rd_in_range ? mem[rd_idx] : '0;
            s_r.resp <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
        end
        if (wr_start) begin
            s_b.resp <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
            for (int i = 0; i < $bits(strb_t); i++) begin
                if (wr_in_range && w_q.strb[i]) mem[wr_idx][8*i +: 8] <= w_q.data[8*i +: 8];
            end
        end
    end

endmodule

/* test/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Reference memory, one known bit per byte lane
data_t model [MEM_WORDS];
strb_t known [MEM_WORDS];

function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];  // Taps 16,14,13,11
    lfsr = {lfsr[14:0], fb};
    return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_bit()};
    end
    return v;
endfunction

function automatic addr_t rand_addr();
    return {22'b0, 8'(rand_bits(8)), 2'b00};
endfunction

function automatic logic in_window(input addr_t a);
    return (a[31:WINDOW_BITS] == '0);
endfunction

task automatic mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
    $display("mismatch time=%0t signal=%s got=%h expected=%h", $time, sig, got, exp);
    errors++;
endtask

task automatic check_read(input string sig, input addr_t a, input r_resp_t r);
    logic [WORD_IDX_BITS-1:0] idx;
    logic [31:0] mask;
    idx = a[WORD_IDX_BITS+1:2];
    for (int i = 0; i < 4; i++) begin
        mask[8*i +: 8] = {8{known[idx][i]}};  // Unwritten bytes are not checked
    end
    if (r.resp !== (in_window(a) ? RESP_OKAY : RESP_SLVERR)) begin
        mismatch({sig, ".resp"}, 32'(r.resp), 32'(in_window(a) ? RESP_OKAY : RESP_SLVERR));
    end else if (in_window(a) && (((r.data ^ model[idx]) & mask) != '0)) begin
        mismatch({sig, ".data"}, r.data, model[idx]);
    end
endtask

task automatic model_write(input addr_t a, input w_req_t w, input resp_t resp);
    logic [WORD_IDX_BITS-1:0] idx;
    idx = a[WORD_IDX_BITS+1:2];
    if (resp !== (in_window(a) ? RESP_OKAY : RESP_SLVERR)) begin
        mismatch("lsu_b.resp", 32'(resp), 32'(in_window(a) ? RESP_OKAY : RESP_SLVERR));
    end
    if (in_window(a)) begin
        for (int i = 0; i < 4; i++) begin
            if (w.strb[i]) begin
                model[idx][8*i +: 8] = w.data[8*i +: 8];
                known[idx][i] = 1'b1;
            end
        end
    end
endtask

// All driver tasks start and end 1 ns after a rising edge
task automatic bus_read(input bit lsu, input addr_t a, output r_resp_t r);
    bit got;
    got = 0;
    if (lsu) begin
        lsu_ar.addr = a;
        lsu_arvalid = 1'b1;
    end else begin
        ifu_ar.addr = a;
        ifu_arvalid = 1'b1;
    end
    do begin
        @(negedge clk);
    end while (!(lsu ? lsu_arready : ifu_arready));
    @(posedge clk);
    #1;
    if (lsu) lsu_arvalid = 1'b0;
    else ifu_arvalid = 1'b0;
    while (!got) begin
        if (lsu) lsu_rready = lfsr_bit() | lfsr_bit();  // Ready three times in four
        else ifu_rready = lfsr_bit() | lfsr_bit();
        @(negedge clk);
        if (lsu && lsu_rvalid && lsu_rready) begin
            r = lsu_r;
            got = 1;
        end
        if (!lsu && ifu_rvalid && ifu_rready) begin
            r = ifu_r;
            got = 1;
        end
        @(posedge clk);
        #1;
    end
    if (lsu) lsu_rready = 1'b0;
    else ifu_rready = 1'b0;
    order_q.push_back(lsu ? 8'h4c : 8'h49);
endtask

task automatic read_check(input bit lsu, input addr_t a);
    r_resp_t r;
    bus_read(lsu, a, r);
    check_read(lsu ? "lsu_r" : "ifu_r", a, r);
endtask

task automatic lsu_wr_phase(input addr_t a, input w_req_t w);
    logic aw_hs;
    logic w_hs;
    lsu_aw.addr = a;
    lsu_w = w;
    lsu_awvalid = 1'b1;
    lsu_wvalid = 1'b1;
    while (lsu_awvalid || lsu_wvalid) begin
        @(negedge clk);
        aw_hs = lsu_awvalid && lsu_awready;
        w_hs = lsu_wvalid && lsu_wready;
        @(posedge clk);
        #1;
        if (aw_hs) lsu_awvalid = 1'b0;
        if (w_hs) lsu_wvalid = 1'b0;
    end
endtask

task automatic lsu_write(input addr_t a, input data_t d, input strb_t s);
    w_req_t w;
    b_resp_t b;
    bit got;
    w.data = d;
    w.strb = s;
    got = 0;
    lsu_wr_phase(a, w);
    while (!got) begin
        lsu_bready = lfsr_bit() | lfsr_bit();
        @(negedge clk);
        if (lsu_bvalid && lsu_bready) begin
            b = lsu_b;
            got = 1;
        end
        @(posedge clk);
        #1;
    end
    lsu_bready = 1'b0;
    model_write(a, w, b.resp);
    order_q.push_back(8'h4c);
endtask

// LSU response held with its ready low while a fetch waits
task automatic check_held(input bit rd);
    r_resp_t r_hold;
    b_resp_t b_hold;
    r_hold = lsu_r;
    b_hold = lsu_b;
    repeat (6) begin
        @(negedge clk);
        if (!(rd ? lsu_rvalid : lsu_bvalid)) begin
            $display("LSU response valid dropped while its ready was low at %0t", $time);
            errors++;
        end
        if (rd && lsu_r.data !== r_hold.data) mismatch("lsu_r.data", lsu_r.data, r_hold.data);
        if (rd && lsu_r.resp !== r_hold.resp) begin
            mismatch("lsu_r.resp", 32'(lsu_r.resp), 32'(r_hold.resp));
        end
        if (!rd && lsu_b.resp !== b_hold.resp) begin
            mismatch("lsu_b.resp", 32'(lsu_b.resp), 32'(b_hold.resp));
        end
        if (ifu_arready) begin
            $display("ifu_arready given while an LSU response was held at %0t", $time);
            errors++;
        end
    end
endtask

`endif

/* test/tb_mem_subsys.sv */
`timescale 1ns/100ps

module tb_mem_subsys import bus_pkg::*, mem_pkg::*;;

    // Fill, strobes, concurrent, out of range, latency, back-pressure
    localparam int N_TXN = 2 * MEM_WORDS + 2 * 64 + 2 + 80 + 6 + 1 + 4;
    localparam int CYCLE_LIMIT = 200 * N_TXN;

    logic clk;
    logic rst;
    logic ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
    ar_req_t ifu_ar;
    r_resp_t ifu_r;
    logic lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
    ar_req_t lsu_ar;
    r_resp_t lsu_r;
    logic lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;
    aw_req_t lsu_aw;
    w_req_t lsu_w;
    b_resp_t lsu_b;

    logic [15:0] lfsr = 16'd25;
    int errors = 0;
    int err_mark = 0;
    int n_pass = 0;
    int n_fail = 0;
    int done_cnt = 0;
    int cycles = 0;
    byte order_q[$];  // Completion order, I or L
    logic ifu_rvalid_d = 1'b0;
    logic lsu_rvalid_d = 1'b0;
    logic lsu_bvalid_d = 1'b0;

    `include "tb_tasks.svh"

    mem_subsys_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run passed the limit of %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Each response is counted once, on the cycle its valid rises
    always @(negedge clk) begin
        if (ifu_rvalid && !ifu_rvalid_d) done_cnt++;
        if (lsu_rvalid && !lsu_rvalid_d) done_cnt++;
        if (lsu_bvalid && !lsu_bvalid_d) done_cnt++;
        ifu_rvalid_d = ifu_rvalid;
        lsu_rvalid_d = lsu_rvalid;
        lsu_bvalid_d = lsu_bvalid;
        if ((ifu_arready || ifu_rvalid)
                && (lsu_arready || lsu_awready || lsu_wready || lsu_rvalid || lsu_bvalid)) begin
            $display("IFU and LSU ports both given ready or valid at %0t", $time);
            errors++;
        end
    end

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            $display("test %s: ok", name);
            n_pass++;
        end else begin
            $display("test %s: failed with %0d errors", name, errors - err_mark);
            n_fail++;
        end
        err_mark = errors;
    endtask

    initial begin
        addr_t a;
        b_resp_t b_hold;
        r_resp_t r_hold;
        w_req_t w;
        int n;
        int start_cnt;
        rst = 1'b1;
        {ifu_arvalid, ifu_rready, lsu_arvalid, lsu_rready} = '0;
        {lsu_awvalid, lsu_wvalid, lsu_bready} = '0;
        ifu_ar = '0;
        lsu_ar = '0;
        lsu_aw = '0;
        lsu_w = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model[i] = '0;
            known[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < MEM_WORDS; i++) lsu_write(32'(i * 4), rand_bits(32), 4'hf);
        for (int i = 0; i < MEM_WORDS; i++) read_check(1'b1, 32'(i * 4));
        end_test("fill_and_read_back");

        repeat (64) lsu_write(rand_addr(), rand_bits(32), strb_t'(rand_bits(4)));
        for (int i = 0; i < 64; i++) read_check(i[0], rand_addr());  // Both ports
        end_test("byte_strobes");

        order_q.delete();
        fork
            read_check(1'b0, rand_addr());
            lsu_write(rand_addr(), rand_bits(32), 4'hf);
        join
        if (order_q[0] != 8'h49) begin
            $display("IFU read lost to an LSU write requested in the same idle cycle");
            errors++;
        end
        start_cnt = done_cnt;
        fork
            repeat (40) read_check(1'b0, rand_addr());
            repeat (40) begin
                if (lfsr_bit()) lsu_write(rand_addr(), rand_bits(32), strb_t'(rand_bits(4)));
                else read_check(1'b1, rand_addr());
            end
        join
        if (done_cnt - start_cnt != 80) begin
            $display("%0d responses seen for 80 concurrent transactions", done_cnt - start_cnt);
            errors++;
        end
        end_test("concurrent_requests");

        lsu_write(32'h0000_0420, 32'hdead_beef, 4'hf);  // Aliases word 8 if decoded wrongly
        read_check(1'b1, 32'h0000_0020);
        read_check(1'b1, 32'h0000_0404);
        read_check(1'b0, 32'h8000_0004);
        lsu_write(32'h0001_0000, 32'h1234_5678, 4'h3);
        read_check(1'b1, 32'h0000_0000);  // Word 0 must survive the write above
        end_test("out_of_range");

        ifu_ar.addr = 32'h0000_0040;
        ifu_arvalid = 1'b1;
        ifu_rready = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            @(negedge clk);
        end while (!ifu_arready);
        if (n != 1) mismatch("ifu_arready delay", 32'(n), 32'd1);
        n = 0;
        @(posedge clk);
        #1;
        ifu_arvalid = 1'b0;
        do begin
            @(posedge clk);
            n++;
            @(negedge clk);
        end while (!ifu_rvalid);
        if (n != MEM_LATENCY) mismatch("ifu_rvalid delay", 32'(n), 32'(MEM_LATENCY));
        check_read("ifu_r", 32'h0000_0040, ifu_r);
        @(posedge clk);
        #1;
        ifu_rready = 1'b0;
        end_test("latency");

        a = 32'h0000_0010;
        w.data = rand_bits(32);
        w.strb = 4'hf;
        lsu_wr_phase(a, w);
        do begin
            @(negedge clk);
        end while (!lsu_bvalid);
        @(posedge clk);
        #1;
        b_hold = lsu_b;
        ifu_ar.addr = a;
        ifu_arvalid = 1'b1;  // Competing fetch while bready stays low
        check_held(1'b0);
        @(posedge clk);
        #1;
        lsu_bready = 1'b1;
        @(posedge clk);
        #1;
        lsu_bready = 1'b0;
        model_write(a, w, b_hold.resp);
        read_check(1'b0, a);

        lsu_ar.addr = a;
        lsu_arvalid = 1'b1;
        do begin
            @(negedge clk);
        end while (!lsu_arready);
        @(posedge clk);
        #1;
        lsu_arvalid = 1'b0;
        do begin
            @(negedge clk);
        end while (!lsu_rvalid);
        @(posedge clk);
        #1;
        r_hold = lsu_r;
        ifu_arvalid = 1'b1;  // Competing fetch while rready stays low
        check_held(1'b1);
        @(posedge clk);
        #1;
        lsu_rready = 1'b1;
        @(posedge clk);
        #1;
        lsu_rready = 1'b0;
        check_read("lsu_r", a, r_hold);
        read_check(1'b0, a);
        end_test("back_pressure");

        $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
